//--- common/graph_write_pkg.sv
// Shared constants and types for the edge-data write path
// Results are 24-bit vertex index plus 32-bit value
// One bus word is 16 bytes, so four results share a line
// Memory is big-endian, values are byte swapped before the write
`default_nettype none

package graph_write_pkg;

	//////////////////////////////////////////////////
	// Item and bus geometry
	//////////////////////////////////////////////////

	// Vertex index width
	localparam int INDEX_W = 24;
	// Bytes per result value
	localparam int ITEM_BYTES = 4;
	localparam int ITEM_W = ITEM_BYTES * 8;
	// Bytes per bus word
	localparam int LINE_BYTES = 16;
	// Result slots in one bus word
	localparam int LANES = LINE_BYTES / ITEM_BYTES;
	// Byte address width
	localparam int ADDR_W = 32;

	//////////////////////////////////////////////////
	// Packed types
	//////////////////////////////////////////////////

	// One result from the vertex kernel
	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [ITEM_W-1:0]  data;
	} edge_data_t;

	// One line write toward the bus master
	typedef struct packed {
		logic [ADDR_W-1:0]       addr;  // Line aligned
		logic [LINE_BYTES-1:0]   sel;   // One bit per byte
		logic [LINE_BYTES*8-1:0] data;
	} line_write_t;

	// Bus master FSM
	typedef enum logic {
		WB_IDLE     = 1'b0,
		WB_WAIT_ACK = 1'b1
	} wb_state_e;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Reverse byte order of one value
	function automatic logic [ITEM_W-1:0] swap_item_bytes(input logic [ITEM_W-1:0] value);
		logic [ITEM_W-1:0] swapped;
		swapped = '0;
		for (int b = 0; b < ITEM_BYTES; b++) begin
			// Lowest byte goes to the top
			swapped[b*8 +: 8] = value[(ITEM_BYTES-1-b)*8 +: 8];
		end
		return swapped;
	endfunction

endpackage

`default_nettype wire

//--- dv/tb_graph_write.sv
// Testbench for the edge-data write path with a random-latency Wishbone memory
// Expected writes are formed from each accepted item and the base in force
// Bases stay 16-byte aligned and change only while enable is low
`timescale 1ns/1ns
`default_nettype none

module tb_graph_write
	import graph_write_pkg::*;
();

	localparam int SEED         = 32'hd97a9ae0;
	localparam int RESET_CYCLES = 4;
	localparam int WAIT_LIMIT   = 400;
	localparam int BURST_ITEMS  = 40;

	logic                    clock;
	logic                    rstn;
	logic                    enable_in;
	logic [ADDR_W-1:0]       cfg_base;
	logic                    in_valid;
	edge_data_t              in_item;
	logic                    in_ready;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [ADDR_W-1:0]       wb_adr;
	logic [LINE_BYTES-1:0]   wb_sel;
	logic [LINE_BYTES*8-1:0] wb_dat_w;
	logic                    wb_ack;

	// Reference model state
	line_write_t             expected_q [$];
	logic [ADDR_W-1:0]       written_addrs [$];
	logic [ITEM_W-1:0]       final_val [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0]       base;
	integer                  stim_seed;
	int                      stall_count = 0;
	int                      write_count = 0;
	int                      accept_count = 0;

	// Previous bus sample
	logic                    prev_hold = 1'b0;
	logic                    prev_ack = 1'b0;
	logic [ADDR_W-1:0]       prev_adr;
	logic [LINE_BYTES-1:0]   prev_sel;
	logic [LINE_BYTES*8-1:0] prev_dat;

	graph_write_top #(
		.QUEUE_DEPTH (4)
	) dut_i (
		.clock     (clock),
		.rstn      (rstn),
		.enable_in (enable_in),
		.cfg_base  (cfg_base),
		.in_valid  (in_valid),
		.in_item   (in_item),
		.in_ready  (in_ready),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_sel    (wb_sel),
		.wb_dat_w  (wb_dat_w),
		.wb_ack    (wb_ack)
	);

	wb_mem_model #(
		.SEED (SEED)
	) mem_i (
		.clock    (clock),
		.rstn     (rstn),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_sel   (wb_sel),
		.wb_dat_w (wb_dat_w),
		.wb_ack   (wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp_v,
			input logic [127:0] act_v);
		stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp_v, act_v));
	endtask

	// Base plus four times the index
	function automatic logic [ADDR_W-1:0] item_addr(input logic [ADDR_W-1:0] b,
			input edge_data_t item);
		return b + {6'd0, item.index, 2'b00};
	endfunction

	// Line write the DUT should issue for one item
	function automatic line_write_t expected_write(input logic [ADDR_W-1:0] b,
			input edge_data_t item);
		line_write_t       w;
		logic [ADDR_W-1:0] byte_addr;
		logic [1:0]        lane;
		byte_addr = item_addr(b, item);
		lane      = item.index[1:0];
		w.addr    = {byte_addr[ADDR_W-1:4], 4'h0};
		w.sel     = 16'h000f << {lane, 2'b00};
		w.data    = {96'd0, swap_item_bytes(item.data)} << {lane, 5'b00000};
		return w;
	endfunction

	// Present one item; caller sits on a falling edge
	task automatic send_item(input edge_data_t item);
		logic [ADDR_W-1:0] a;
		int                n;
		n        = 0;
		in_valid = 1'b1;
		in_item  = item;
		// in_ready comes from registers only and is stable here
		while (!in_ready) begin
			if (n == WAIT_LIMIT) begin
				stop_with_failure("timeout waiting for in_ready");
			end
			stall_count++;
			@(negedge clock);
			n++;
		end
		// Transfer happens on the coming rising edge
		expected_q.push_back(expected_write(base, item));
		a = item_addr(base, item);
		written_addrs.push_back(a);
		final_val[a] = item.data;
		@(negedge clock);
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (expected_q.size() != 0 || wb_cyc) begin
			if (n == WAIT_LIMIT) begin
				stop_with_failure($sformatf("timeout waiting for writes to drain, master in %s",
					dut_i.master_i.state.name()));
			end
			@(negedge clock);
			n++;
		end
	endtask

	//////////////////////////////////////////////////
	// Bus checks
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		line_write_t exp_w;
		if (rstn) begin
			// Handshakes as the DUT sees them
			if (in_valid && in_ready) begin
				accept_count++;
			end
			assert (wb_cyc == wb_stb) else stop_with_failure("wb_cyc and wb_stb differ");
			// Held cycle must stay put until ack
			if (prev_hold) begin
				assert (wb_cyc) else stop_with_failure("wb_cyc dropped before ack");
				assert (wb_adr == prev_adr) else
					report_mismatch("wb_adr", 128'(prev_adr), 128'(wb_adr));
				assert (wb_sel == prev_sel) else
					report_mismatch("wb_sel", 128'(prev_sel), 128'(wb_sel));
				assert (wb_dat_w == prev_dat) else report_mismatch("wb_dat_w", prev_dat, wb_dat_w);
			end
			if (prev_ack) begin
				assert (!wb_cyc) else stop_with_failure("bus not released for a cycle after ack");
			end
			if (wb_cyc && wb_stb && wb_ack) begin
				assert (expected_q.size() != 0) else stop_with_failure("write with no accepted item");
				exp_w = expected_q.pop_front();
				assert (wb_we) else stop_with_failure("wb_we low during a write");
				assert (wb_adr == exp_w.addr) else
					report_mismatch("wb_adr", 128'(exp_w.addr), 128'(wb_adr));
				assert (wb_sel == exp_w.sel) else
					report_mismatch("wb_sel", 128'(exp_w.sel), 128'(wb_sel));
				assert (wb_dat_w == exp_w.data) else report_mismatch("wb_dat_w", exp_w.data, wb_dat_w);
				write_count++;
			end
		end
		prev_hold = wb_cyc && wb_stb && !wb_ack;
		prev_ack  = wb_cyc && wb_stb && wb_ack;
		prev_adr  = wb_adr;
		prev_sel  = wb_sel;
		prev_dat  = wb_dat_w;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		edge_data_t              item;
		logic [ADDR_W-1:0]       a;
		logic [LINE_BYTES*8-1:0] line;
		logic [ITEM_W-1:0]       got;
		stim_seed = SEED;
		rstn      = 1'b0;
		enable_in = 1'b0;
		cfg_base  = 32'h0001_0000;
		base      = 32'h0001_0000;
		// Offered while disabled and must not be taken
		in_valid  = 1'b1;
		in_item   = {24'h000001, 32'hdeadbeef};

		// Reset, then disabled with in_valid high
		for (int c = 0; c < 10; c++) begin
			@(negedge clock);
			if (c == RESET_CYCLES - 1) begin
				rstn = 1'b1;
			end
			assert (!in_ready) else stop_with_failure("in_ready high while disabled");
			assert (!wb_cyc) else stop_with_failure("wb_cyc high while disabled");
		end
		in_valid  = 1'b0;
		enable_in = 1'b1;

		// All four lanes and values with distinct bytes
		for (int i = 0; i < 8; i++) begin
			item.index = 24'h000010 + 24'(i);
			item.data  = 32'h0a1b2c3d + 32'(i) * 32'h01010101;
			send_item(item);
		end
		in_valid = 1'b0;
		wait_drained();

		// Random burst with in_valid held high throughout
		stall_count = 0;
		for (int i = 0; i < BURST_ITEMS; i++) begin
			item.index = INDEX_W'($unsigned($random(stim_seed)));
			item.data  = $random(stim_seed);
			send_item(item);
		end
		in_valid = 1'b0;

		// Disable with items still queued and let them drain
		enable_in = 1'b0;
		wait_drained();
		assert (stall_count > 0) else stop_with_failure("in_ready never fell during the burst");
		@(negedge clock);
		assert (!in_ready) else stop_with_failure("in_ready high after disable");

		// Move the base while disabled
		cfg_base = 32'h0040_0080;
		base     = 32'h0040_0080;
		@(negedge clock);
		enable_in = 1'b1;

		// Same indices as before at new addresses
		for (int i = 0; i < 8; i++) begin
			item.index = 24'h000010 + 24'(i);
			item.data  = 32'h8899aabb + 32'(i) * 32'h01010101;
			send_item(item);
		end
		in_valid = 1'b0;
		wait_drained();

		// One write per accepted handshake
		assert (write_count == accept_count) else
			report_mismatch("write_count", 128'(accept_count), 128'(write_count));

		// Memory holds last value per address in big-endian order
		for (int i = 0; i < written_addrs.size(); i++) begin
			a    = written_addrs[i];
			line = mem_i.lines[a[ADDR_W-1:4]];
			got  = line[{a[3:2], 5'b00000} +: ITEM_W];
			assert (got == swap_item_bytes(final_val[a])) else
				report_mismatch("mem_line", 128'(swap_item_bytes(final_val[a])), 128'(got));
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/wb_mem_model.sv
// Wishbone classic slave memory for the testbench
// Acks each cycle after 0 to 3 extra clocks, picked by a seeded $random
// Stores 16-byte lines merged under wb_sel, writes only, no err or rty
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model
	import graph_write_pkg::*;
#(
	parameter int SEED = 32'hd97a9ae0
) (
	input  wire logic                    clock,
	input  wire logic                    rstn,
	input  wire logic                    wb_cyc,
	input  wire logic                    wb_stb,
	input  wire logic                    wb_we,
	input  wire logic [ADDR_W-1:0]       wb_adr,
	input  wire logic [LINE_BYTES-1:0]   wb_sel,
	input  wire logic [LINE_BYTES*8-1:0] wb_dat_w,
	output logic                         wb_ack
);

	// Written lines, keyed by the line address above the 16-byte offset
	logic [LINE_BYTES*8-1:0] lines [logic [ADDR_W-5:0]];

	integer     seed;
	logic       busy;
	logic [1:0] wait_left;

	initial seed = SEED;

	// Merge the bus word into its line
	task automatic store_write();
		logic [LINE_BYTES*8-1:0] line;
		logic [ADDR_W-5:0]       key;
		key  = wb_adr[ADDR_W-1:4];
		line = '0;
		if (lines.exists(key)) begin
			line = lines[key];
		end
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (wb_sel[b]) begin
				line[b*8 +: 8] = wb_dat_w[b*8 +: 8];
			end
		end
		lines[key] = line;
	endtask

	//////////////////////////////////////////////////
	// Ack with random latency
	//////////////////////////////////////////////////

	always @(posedge clock or negedge rstn) begin
		logic [1:0] delay;
		if (!rstn) begin
			wb_ack    <= 1'b0;
			busy      <= 1'b0;
			wait_left <= 2'd0;
		end else begin
			// Ack is a one-clock pulse
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!busy) begin
					// New cycle, pick its delay
					delay = 2'($unsigned($random(seed)));
					if (delay == 2'd0) begin
						wb_ack <= 1'b1;
						if (wb_we) begin
							store_write();
						end
					end else begin
						busy      <= 1'b1;
						wait_left <= delay - 2'd1;
					end
				end else if (wait_left == 2'd0) begin
					wb_ack <= 1'b1;
					busy   <= 1'b0;
					if (wb_we) begin
						store_write();
					end
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- graph_write.f
common/graph_write_pkg.sv
src/edge_data_input_queue.sv
write_control/edge_data_write_control.sv
src/wb_line_write_master.sv
src/graph_write_top.sv
dv/wb_mem_model.sv
dv/tb_graph_write.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the edge-data write path testbench with Verilator.
# A failing check ends the simulation with $fatal, which gives a non-zero exit status.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f graph_write.f \
	--top-module tb_graph_write \
	-o tb_graph_write

./obj_dir/tb_graph_write

//--- src/edge_data_input_queue.sv
// Circular FIFO for edge-data results with valid/ready on both sides
// QUEUE_DEPTH must be a power of two, at least 2
// Intake stops one clock after enable_in falls, queued items still drain
`timescale 1ns/1ns
`default_nettype none

module edge_data_input_queue
	import graph_write_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic       clock,
	input  wire logic       rstn,
	input  wire logic       enable_in,
	// Push side
	input  wire logic       in_valid,
	input  wire edge_data_t in_item,
	output logic            in_ready,
	// Pop side
	output logic            q_valid,
	output edge_data_t      q_item,
	input  wire logic       q_ready
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(QUEUE_DEPTH);

	// Storage
	edge_data_t       mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic             enabled;
	logic             push;
	logic             pop;

	//////////////////////////////////////////////////
	// Enable register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable_in;
		end
	end

	//////////////////////////////////////////////////
	// Handshakes
	//////////////////////////////////////////////////

	// No intake while disabled or full
	assign in_ready = enabled && (count != FULL_COUNT);
	assign q_valid  = (count != '0);
	assign q_item   = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = q_valid && q_ready;

	//////////////////////////////////////////////////
	// Pointers and fill level
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap on their own, depth is a power of two
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Data array
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= in_item;
		end
	end

endmodule

`default_nettype wire

//--- src/graph_write_top.sv
// Result write path of one compute unit
// Input queue, write control and Wishbone classic master in a chain
// cfg_base must be 16-byte aligned and may change only while disabled
`timescale 1ns/1ns
`default_nettype none

module graph_write_top
	import graph_write_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic                    clock,
	input  wire logic                    rstn,
	input  wire logic                    enable_in,
	input  wire logic [ADDR_W-1:0]       cfg_base,
	// Result stream from the kernel
	input  wire logic                    in_valid,
	input  wire edge_data_t              in_item,
	output logic                         in_ready,
	// Wishbone classic master
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output logic [ADDR_W-1:0]            wb_adr,
	output logic [LINE_BYTES-1:0]        wb_sel,
	output logic [LINE_BYTES*8-1:0]      wb_dat_w,
	input  wire logic                    wb_ack
);

	// Queue to control
	logic        q_valid;
	edge_data_t  q_item;
	logic        q_ready;

	// Control to bus master
	logic        req_valid;
	line_write_t req;
	logic        req_ready;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	edge_data_input_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) queue_i (
		.clock     (clock),
		.rstn      (rstn),
		.enable_in (enable_in),
		.in_valid  (in_valid),
		.in_item   (in_item),
		.in_ready  (in_ready),
		.q_valid   (q_valid),
		.q_item    (q_item),
		.q_ready   (q_ready)
	);

	//////////////////////////////////////////////////
	// Address and line forming
	//////////////////////////////////////////////////

	edge_data_write_control control_i (
		.clock     (clock),
		.rstn      (rstn),
		.enable_in (enable_in),
		.cfg_base  (cfg_base),
		.q_valid   (q_valid),
		.q_item    (q_item),
		.q_ready   (q_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready)
	);

	//////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////

	wb_line_write_master master_i (
		.clock     (clock),
		.rstn      (rstn),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_sel    (wb_sel),
		.wb_dat_w  (wb_dat_w),
		.wb_ack    (wb_ack)
	);

endmodule

`default_nettype wire

//--- src/wb_line_write_master.sv
// Wishbone classic master, one single write per request
// cyc and stb stay high until ack, then drop for at least one clock
// No err or rty handling, every cycle is expected to end in ack
`timescale 1ns/1ns
`default_nettype none

module wb_line_write_master
	import graph_write_pkg::*;
(
	input  wire logic               clock,
	input  wire logic               rstn,
	// Request from control
	input  wire logic               req_valid,
	input  wire line_write_t        req,
	output logic                    req_ready,
	// Wishbone classic
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [ADDR_W-1:0]       wb_adr,
	output logic [LINE_BYTES-1:0]   wb_sel,
	output logic [LINE_BYTES*8-1:0] wb_dat_w,
	input  wire logic               wb_ack
);

	wb_state_e state;
	wb_state_e state_next;
	logic      start;
	logic      done;

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	// Only take a request with the bus idle
	assign req_ready = (state == WB_IDLE);
	assign start     = req_valid && req_ready;
	assign done      = (state == WB_WAIT_ACK) && wb_ack;

	always_comb begin
		state_next = state;
		case (state)
			WB_IDLE: begin
				if (start) begin
					state_next = WB_WAIT_ACK;
				end
			end
			WB_WAIT_ACK: begin
				// Ack latency is open ended
				if (wb_ack) begin
					state_next = WB_IDLE;
				end
			end
			default: state_next = WB_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= WB_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////
	// Bus control lines
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end else if (start) begin
			// Raised together, one clock after accept
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_we  <= 1'b1;
		end else if (done) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end
	end

	// Address, select and data stay put until ack
	always_ff @(posedge clock) begin
		if (start) begin
			wb_adr   <= req.addr;
			wb_sel   <= req.sel;
			wb_dat_w <= req.data;
		end
	end

endmodule

`default_nettype wire

//--- write_control/edge_data_write_control.sv
// Turns one edge-data result into one line write request
// Base is taken from cfg_base while disabled and frozen while enabled
// Base must be 16-byte aligned, the lane comes from the index alone
`timescale 1ns/1ns
`default_nettype none

module edge_data_write_control
	import graph_write_pkg::*;
(
	input  wire logic              clock,
	input  wire logic              rstn,
	input  wire logic              enable_in,
	input  wire logic [ADDR_W-1:0] cfg_base,
	// From the input queue
	input  wire logic              q_valid,
	input  wire edge_data_t        q_item,
	output logic                   q_ready,
	// To the bus master
	output logic                   req_valid,
	output line_write_t            req,
	input  wire logic              req_ready
);

	localparam int ITEM_SHIFT = $clog2(ITEM_BYTES);
	localparam int LANE_W     = $clog2(LANES);

	logic              enabled;
	logic [ADDR_W-1:0] base_latched;

	// Request forming
	logic [ADDR_W-1:0] byte_addr;
	logic [LANE_W-1:0] lane;
	line_write_t       next_req;
	logic              pop;

	//////////////////////////////////////////////////
	// Enable and configuration
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable_in;
		end
	end

	// Follows cfg_base until enabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			base_latched <= '0;
		end else if (!enabled) begin
			base_latched <= cfg_base;
		end
	end

	//////////////////////////////////////////////////
	// Address, select and line data
	//////////////////////////////////////////////////

	always_comb begin
		// Item address inside the result array
		byte_addr = base_latched + (ADDR_W'(q_item.index) << ITEM_SHIFT);
		lane      = q_item.index[LANE_W-1:0];

		next_req      = '0;
		next_req.addr = byte_addr & ~ADDR_W'(LINE_BYTES - 1);
		// Only this lane's bytes are written
		next_req.sel[lane*ITEM_BYTES +: ITEM_BYTES] = '1;
		// Big-endian value in its lane, rest zero
		next_req.data[lane*ITEM_W +: ITEM_W] = swap_item_bytes(q_item.data);
	end

	//////////////////////////////////////////////////
	// One-entry output register
	//////////////////////////////////////////////////

	// Free when empty or when the held request leaves this cycle
	assign q_ready = !req_valid || req_ready;
	assign pop     = q_valid && q_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			req_valid <= 1'b0;
		end else if (q_ready) begin
			req_valid <= q_valid;
		end
	end

	// Payload held until accepted
	always_ff @(posedge clock) begin
		if (pop) begin
			req <= next_req;
		end
	end

endmodule

`default_nettype wire
